//--- bench/hpm_ref_model.svh
`ifndef HPM_REF_MODEL_SVH
`define HPM_REF_MODEL_SVH

// ----------------------------------------
// reference state of the tile
// ----------------------------------------
logic [`HPM_SEL_WIDTH-1:0]      ref_sel [`HPM_NUM_COUNTERS];
logic [`HPM_CNT_WIDTH-1:0]      ref_cnt [`HPM_NUM_COUNTERS];
logic [`HPM_NUM_COUNTERS-1:0]   ref_inhibit;
logic [`HPM_NUM_COUNTERS-1:0]   ref_ovf;
logic [`HPM_NUM_EVENTS-1:0]     ref_events;     // sampled flags, bit k = event k+1
logic                           ref_irq;

function automatic logic [`CSR_ADDR_WIDTH-1:0] event_addr(input int idx);
    return 12'(`CSR_MHPMEVENT_BASE + idx);
endfunction

function automatic logic [`CSR_ADDR_WIDTH-1:0] counter_addr(input int idx);
    return 12'(`CSR_MHPMCOUNTER_BASE + idx);
endfunction

task automatic reset_model();
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
        ref_sel[i] = '0;
        ref_cnt[i] = '0;
    end
    ref_inhibit = '0;
    ref_ovf     = '0;
    ref_events  = '0;
    ref_irq     = 1'b0;
endtask

// one rising edge, inputs as driven during the cycle before it
task automatic step_model(input logic we, input logic [`CSR_ADDR_WIDTH-1:0] addr,
                          input logic [31:0] wdata, input logic [`HPM_NUM_EVENTS-1:0] ev);
    logic [`HPM_NUM_COUNTERS-1:0] inc;
    logic [`HPM_NUM_COUNTERS-1:0] wrap;
    logic [`HPM_NUM_COUNTERS-1:0] clr;
    int                           num;
    inc  = '0;
    wrap = '0;
    clr  = '0;
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
        num = int'(ref_sel[i]);
        if (num >= 1 && num <= `HPM_NUM_EVENTS) begin      // 0 and >16 count nothing
            inc[i] = ref_events[num-1] & ~ref_inhibit[i];
        end
    end
    ref_irq = |ref_ovf;                                     // from the bits before this edge
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
        if (we && addr == counter_addr(i)) begin
            ref_cnt[i] = wdata;                             // write beats increment
        end else if (inc[i]) begin
            wrap[i]    = (ref_cnt[i] == '1);
            ref_cnt[i] = ref_cnt[i] + 32'd1;
        end
        if (we && addr == event_addr(i)) begin
            ref_sel[i] = wdata[`HPM_SEL_WIDTH-1:0];
        end
    end
    if (we && addr == `CSR_HPM_OVF) begin
        clr = wdata[`HPM_NUM_COUNTERS-1:0];
    end
    ref_ovf = (ref_ovf & ~clr) | wrap;                      // new wrap survives a clear
    if (we && addr == `CSR_MCOUNTINHIBIT) begin
        ref_inhibit = wdata[`HPM_NUM_COUNTERS-1:0];
    end
    ref_events = ev;
endtask

// value a read issued now must return
function automatic logic [31:0] expected_read(input logic [`CSR_ADDR_WIDTH-1:0] addr);
    logic [31:0] val;
    val = '0;                                               // unmapped reads give zero
    if (addr == `CSR_MCOUNTINHIBIT) val = 32'(ref_inhibit);
    if (addr == `CSR_HPM_OVF) val = 32'(ref_ovf);
    for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
        if (addr == event_addr(i)) val = 32'(ref_sel[i]);
        if (addr == counter_addr(i)) val = ref_cnt[i];
    end
    return val;
endfunction

`endif

//--- bench/pmu_tile_tb.sv
`default_nettype none

`include "hpm_consts.svh"

module pmu_tile_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 5;
    localparam int RANDOM_CYCLES = 200;
    // reset, reset values, round trip, random, inhibit, overflow, soft reset
    localparam int TEST_CYCLES   = RESET_CYCLES + 12 + 18 + (RANDOM_CYCLES + 12) + 44 + 45 + 22;
    localparam int WATCHDOG_TIME = TEST_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h03f8_8c8b;

    logic                           clk;
    logic                           rstn;
    logic                           soft_rstn;
    logic [`HPM_PIPE_EVENTS-1:0]    pipe_ev;
    logic [`HPM_MEM_EVENTS-1:0]     mem_ev;
    logic [`HPM_EXT_EVENTS-1:0]     ext_ev;
    logic                           csr_re;
    logic                           csr_we;
    logic [`CSR_ADDR_WIDTH-1:0]     csr_addr;
    logic [31:0]                    csr_wdata;
    logic [31:0]                    csr_rdata;
    logic                           csr_rvalid;
    logic                           ovf_irq;
    int                             error_count;
    int                             check_count;
    logic [31:0]                    rnd_state;

    `include "hpm_ref_model.svh"

    pmu_tile_top DUT (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .soft_rstn_i   (soft_rstn),
        .pipe_events_i (pipe_ev),
        .mem_events_i  (mem_ev),
        .ext_events_i  (ext_ev),
        .csr_re_i      (csr_re),
        .csr_we_i      (csr_we),
        .csr_addr_i    (csr_addr),
        .csr_wdata_i   (csr_wdata),
        .csr_rdata_o   (csr_rdata),
        .csr_rvalid_o  (csr_rvalid),
        .ovf_irq_o     (ovf_irq)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // model follows the dut edge by edge
    always @(posedge clk) begin
        if (!(rstn && soft_rstn)) begin
            reset_model();
        end else begin
            step_model(csr_we, csr_addr, csr_wdata, {ext_ev, mem_ev, pipe_ev});
        end
    end

    // ----------------------------------------
    // helpers, all start and end at a falling edge
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [`CSR_ADDR_WIDTH-1:0] mapped_addr(input int k);
        if (k < 4) return event_addr(k);                // mhpmevent3..6
        if (k < 8) return counter_addr(k - 4);          // mhpmcounter3..6
        if (k == 8) return `CSR_MCOUNTINHIBIT;
        return `CSR_HPM_OVF;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic write_csr(input logic [`CSR_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        csr_we    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(negedge clk);
        csr_we    = 1'b0;
    endtask

    // response is due one edge after the strobe
    task automatic read_and_check(input string name, input logic [`CSR_ADDR_WIDTH-1:0] addr,
                                  input logic [31:0] exp);
        csr_re   = 1'b1;
        csr_addr = addr;
        @(negedge clk);
        csr_re   = 1'b0;
        if (csr_rvalid !== 1'b1) begin
            error_count++;
            $display("%s: no read response for address %h", name, addr);
        end else begin
            check_value(name, exp, csr_rdata);
        end
    endtask

    // no read strobe at the edge before, so rvalid must be low
    task automatic run_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            check_value("irq_level", 32'(ref_irq), 32'(ovf_irq));
            check_value("rvalid_idle", 32'h0, 32'(csr_rvalid));
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] held [`HPM_NUM_COUNTERS];
        int          waited;
        clk = 1'b0;
        rstn = 1'b0;
        soft_rstn = 1'b1;
        pipe_ev = '0;
        mem_ev = '0;
        ext_ev = '0;
        csr_re = 1'b0;
        csr_we = 1'b0;
        csr_addr = '0;
        csr_wdata = '0;
        error_count = 0;
        check_count = 0;
        rnd_state = SEED;
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        // 1 reset values
        for (int k = 0; k < 10; k++) read_and_check("reset_values", mapped_addr(k), 32'h0);
        check_value("reset_irq", 32'h0, 32'(ovf_irq));

        // 2 round trip, selectors keep 5 bits
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
            rnd_state = xorshift32(rnd_state);
            write_csr(event_addr(i), rnd_state);
            read_and_check("sel_roundtrip", event_addr(i), {27'b0, rnd_state[4:0]});
            rnd_state = xorshift32(rnd_state);
            write_csr(counter_addr(i), rnd_state);
            read_and_check("cnt_roundtrip", counter_addr(i), rnd_state);
        end

        // 3 random counting, selectors 0..17 so "count nothing" is hit too
        write_csr(`CSR_MCOUNTINHIBIT, 32'h0);
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
            rnd_state = xorshift32(rnd_state);
            write_csr(event_addr(i), rnd_state % 32'd18);
        end
        repeat (RANDOM_CYCLES) begin
            rnd_state = xorshift32(rnd_state);
            {ext_ev, mem_ev, pipe_ev} = rnd_state[15:0];
            run_cycles(1);
        end
        {ext_ev, mem_ev, pipe_ev} = '0;
        run_cycles(2);                                  // drain the sample register
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
            read_and_check("random_count", counter_addr(i), expected_read(counter_addr(i)));
        end

        // 4 inhibit, counters select events 1..4 held high
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) write_csr(event_addr(i), 32'(i + 1));
        write_csr(`CSR_MCOUNTINHIBIT, 32'h5);           // counters 3 and 5 stop
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) held[i] = expected_read(counter_addr(i));
        pipe_ev = '1;
        run_cycles(30);
        pipe_ev = '0;
        run_cycles(2);
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
            if (i % 2 == 0) begin
                read_and_check("inhibit_hold", counter_addr(i), held[i]);
            end else begin
                read_and_check("inhibit_count", counter_addr(i), held[i] + 32'd30);
            end
        end
        write_csr(`CSR_MCOUNTINHIBIT, 32'h0);

        // 5 overflow on counter 3 from external event 15
        write_csr(`CSR_HPM_OVF, 32'hf);
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) write_csr(event_addr(i), 32'(i == 0 ? 15 : 0));
        write_csr(counter_addr(0), 32'hffff_fffd);
        ext_ev = 2'b01;
        waited = 0;
        while (ovf_irq !== 1'b1 && waited < 20) begin
            run_cycles(1);
            waited++;
        end
        if (ovf_irq !== 1'b1) begin
            error_count++;
            $display("overflow interrupt did not rise after the counter wrapped");
        end
        ext_ev = '0;
        read_and_check("ovf_bit", `CSR_HPM_OVF, 32'h1);
        read_and_check("ovf_counter", counter_addr(0), expected_read(counter_addr(0)));
        write_csr(`CSR_HPM_OVF, 32'h1);                 // write 1 to clear
        waited = 0;
        while (ovf_irq !== 1'b0 && waited < 10) begin
            run_cycles(1);
            waited++;
        end
        if (ovf_irq !== 1'b0) begin
            error_count++;
            $display("overflow interrupt stayed high after the clear");
        end
        read_and_check("ovf_cleared", `CSR_HPM_OVF, 32'h0);

        // 6 soft reset clears everything, an overflow is left pending first
        write_csr(counter_addr(0), 32'hffff_ffff);
        ext_ev = 2'b01;                                 // counter 3 still selects event 15
        run_cycles(4);
        ext_ev = '0;
        check_value("soft_reset_pre_irq", 32'h1, 32'(ovf_irq));
        write_csr(`CSR_MCOUNTINHIBIT, 32'ha);
        write_csr(event_addr(1), 32'h3);
        soft_rstn = 1'b0;
        @(negedge clk);
        soft_rstn = 1'b1;
        @(negedge clk);
        for (int k = 0; k < 10; k++) read_and_check("soft_reset", mapped_addr(k), 32'h0);
        check_value("soft_reset_irq", 32'h0, 32'(ovf_irq));

        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d time units, tests did not finish", WATCHDOG_TIME);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- pmu_tile.f
+incdir+source
+incdir+bench
source/hpm_types_pkg.sv
source/csr_access_pkg.sv
source/hpm_event_select.sv
source/hpm_counter_bank.sv
source/hpm_csr_port.sv
source/pmu_tile_top.sv
bench/pmu_tile_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the pmu tile testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=pmu_tile_sim

if ! verilator --binary --timing --assert -j 0 \
        -f pmu_tile.f --top-module pmu_tile_tb \
        -Mdir "$build_dir" -o "$sim_bin"; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$("./$build_dir/$sim_bin")
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1

//--- source/csr_access_pkg.sv
`default_nettype none

`include "hpm_consts.svh"

package csr_access_pkg;

    // ----------------------------------------
    // csr port types
    // ----------------------------------------

    // 12 bit csr address as in the privileged spec
    typedef logic [`CSR_ADDR_WIDTH-1:0] csr_addr_t;

    // write data in and registered read data out
    // narrower registers are zero extended on read
    typedef logic [`CSR_DATA_WIDTH-1:0] csr_data_t;

endpackage

`default_nettype wire

//--- source/hpm_consts.svh
`ifndef HPM_CONSTS_SVH
`define HPM_CONSTS_SVH

// ----------------------------------------
// event and counter sizing
// ----------------------------------------
`define HPM_NUM_EVENTS       16     // numbered 1..16
`define HPM_PIPE_EVENTS      8      // events 1..8
`define HPM_MEM_EVENTS       6      // events 9..14
`define HPM_EXT_EVENTS       2      // events 15..16, external cache
`define HPM_NUM_COUNTERS     4      // mhpmcounter3..6
`define HPM_CNT_WIDTH        32
`define HPM_SEL_WIDTH        5      // 0 = no event

// ----------------------------------------
// csr access
// ----------------------------------------
`define CSR_ADDR_WIDTH       12
`define CSR_DATA_WIDTH       32
`define CSR_MCOUNTINHIBIT    12'h320
`define CSR_MHPMEVENT_BASE   12'h323    // mhpmevent3
`define CSR_MHPMCOUNTER_BASE 12'hB03    // mhpmcounter3
`define CSR_HPM_OVF          12'h7C0    // sticky overflow, write 1 to clear

`endif

//--- source/hpm_counter_bank.sv
`default_nettype none

`include "hpm_consts.svh"

module hpm_counter_bank (
    input  wire logic                                        clk_i,
    input  wire logic                                        tile_rstn,
    input  wire hpm_types_pkg::cnt_mask_t                    cnt_inc_i,     // already inhibit masked
    input  wire hpm_types_pkg::cnt_mask_t                    cnt_we_i,      // one hot
    input  wire hpm_types_pkg::counter_t                     cnt_wdata_i,
    input  wire logic                                        inhibit_we_i,
    input  wire logic                                        ovf_clr_we_i,
    input  wire hpm_types_pkg::cnt_mask_t                    mask_wdata_i,  // inhibit or w1c data
    output hpm_types_pkg::counter_t [`HPM_NUM_COUNTERS-1:0]  counters_o,
    output hpm_types_pkg::cnt_mask_t                         inhibit_o,
    output hpm_types_pkg::cnt_mask_t                         ovf_bits_o
);

    import hpm_types_pkg::*;

    counter_t [`HPM_NUM_COUNTERS-1:0]   cnt_q;
    counter_t [`HPM_NUM_COUNTERS-1:0]   cnt_d;
    cnt_mask_t                          inhibit_q;
    cnt_mask_t                          ovf_q;
    cnt_mask_t                          ovf_d;
    cnt_mask_t                          wrap;       // counter goes all ones -> zero this edge
    cnt_mask_t                          ovf_clr;    // bits written with 1 to the ovf csr

    // ----------------------------------------
    // counter next state
    // ----------------------------------------

    always_comb begin
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
            cnt_d[i] = cnt_q[i];                        // hold by default
            wrap[i]  = 1'b0;
            if (cnt_we_i[i]) begin
                cnt_d[i] = cnt_wdata_i;                 // csr write beats the increment
            end else if (cnt_inc_i[i]) begin
                cnt_d[i] = cnt_q[i] + counter_t'(1);
                wrap[i]  = &cnt_q[i];                   // all ones rolls over
            end
        end
    end

    always_ff @(posedge clk_i, negedge tile_rstn) begin
        if (!tile_rstn) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // ----------------------------------------
    // inhibit mask
    // ----------------------------------------

    always_ff @(posedge clk_i, negedge tile_rstn) begin
        if (!tile_rstn) begin
            inhibit_q <= '0;                            // everything counts out of reset
        end else if (inhibit_we_i) begin
            inhibit_q <= mask_wdata_i;
        end
    end

    // ----------------------------------------
    // sticky overflow bits
    // ----------------------------------------

    assign ovf_clr = ovf_clr_we_i ? mask_wdata_i : '0;

    // a wrap on the same edge as the clear wins, so no event is lost
    assign ovf_d = (ovf_q & ~ovf_clr) | wrap;

    always_ff @(posedge clk_i, negedge tile_rstn) begin
        if (!tile_rstn) begin
            ovf_q <= '0;
        end else begin
            ovf_q <= ovf_d;
        end
    end

    assign counters_o = cnt_q;
    assign inhibit_o  = inhibit_q;
    assign ovf_bits_o = ovf_q;

    // only one counter address can be decoded per write
    a_cnt_we_onehot : assert property (
        @(posedge clk_i) disable iff (!tile_rstn) $onehot0(cnt_we_i)
    ) else $error("hpm_counter_bank: more than one counter write strobe");

endmodule

`default_nettype wire

//--- source/hpm_csr_port.sv
`default_nettype none

`include "hpm_consts.svh"

module hpm_csr_port (
    input  wire logic                                             clk_i,
    input  wire logic                                             tile_rstn,
    input  wire logic                                             csr_re_i,
    input  wire logic                                             csr_we_i,
    input  wire csr_access_pkg::csr_addr_t                        csr_addr_i,
    input  wire csr_access_pkg::csr_data_t                        csr_wdata_i,
    input  wire hpm_types_pkg::event_sel_t [`HPM_NUM_COUNTERS-1:0] sel_i,
    input  wire hpm_types_pkg::counter_t [`HPM_NUM_COUNTERS-1:0]   counters_i,
    input  wire hpm_types_pkg::cnt_mask_t                         inhibit_i,
    input  wire hpm_types_pkg::cnt_mask_t                         ovf_bits_i,
    output hpm_types_pkg::cnt_mask_t                              sel_we_o,
    output hpm_types_pkg::cnt_mask_t                              cnt_we_o,
    output logic                                                  inhibit_we_o,
    output logic                                                  ovf_clr_we_o,
    output csr_access_pkg::csr_data_t                             csr_rdata_o,
    output logic                                                  csr_rvalid_o,
    output logic                                                  ovf_irq_o
);

    import csr_access_pkg::*;

    csr_data_t  rdata_d;        // read mux out
    csr_data_t  rdata_q;
    logic       rvalid_q;
    logic       irq_q;

    // ----------------------------------------
    // write decode, combinational
    // ----------------------------------------

    always_comb begin
        sel_we_o     = '0;
        cnt_we_o     = '0;
        inhibit_we_o = 1'b0;
        ovf_clr_we_o = 1'b0;
        if (csr_we_i) begin
            inhibit_we_o = (csr_addr_i == `CSR_MCOUNTINHIBIT);
            // writing all zeros to the w1c register would clear nothing
            ovf_clr_we_o = (csr_addr_i == `CSR_HPM_OVF) &&
                           (|csr_wdata_i[`HPM_NUM_COUNTERS-1:0]);
            for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
                sel_we_o[i] = (csr_addr_i == csr_addr_t'(`CSR_MHPMEVENT_BASE + i));
                cnt_we_o[i] = (csr_addr_i == csr_addr_t'(`CSR_MHPMCOUNTER_BASE + i));
            end
        end
    end

    // ----------------------------------------
    // read mux, unmapped reads give zero
    // ----------------------------------------

    always_comb begin
        rdata_d = '0;
        if (csr_addr_i == `CSR_MCOUNTINHIBIT) begin
            rdata_d = csr_data_t'(inhibit_i);
        end
        if (csr_addr_i == `CSR_HPM_OVF) begin
            rdata_d = csr_data_t'(ovf_bits_i);
        end
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
            if (csr_addr_i == csr_addr_t'(`CSR_MHPMEVENT_BASE + i)) begin
                rdata_d = csr_data_t'(sel_i[i]);        // zero extended selector
            end
            if (csr_addr_i == csr_addr_t'(`CSR_MHPMCOUNTER_BASE + i)) begin
                rdata_d = csr_data_t'(counters_i[i]);
            end
        end
    end

    // ----------------------------------------
    // registered response and interrupt
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (csr_re_i) begin
            rdata_q <= rdata_d;     // only meaningful while rvalid is high
        end
    end

    always_ff @(posedge clk_i, negedge tile_rstn) begin
        if (!tile_rstn) begin
            rvalid_q <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            rvalid_q <= csr_re_i;           // single cycle pulse per read
            irq_q    <= |ovf_bits_i;        // level, follows the sticky bits
        end
    end

    assign csr_rdata_o  = rdata_q;
    assign csr_rvalid_o = rvalid_q;
    assign ovf_irq_o    = irq_q;

    // the address map gives each register its own address, a write lands in one at most
    a_wr_decode_onehot : assert property (
        @(posedge clk_i) disable iff (!tile_rstn)
            $onehot0({sel_we_o, cnt_we_o, inhibit_we_o, ovf_clr_we_o})
    ) else $error("hpm_csr_port: csr address decodes to more than one register");

endmodule

`default_nettype wire

//--- source/hpm_event_select.sv
`default_nettype none

`include "hpm_consts.svh"

module hpm_event_select (
    input  wire logic                                          clk_i,
    input  wire logic                                          tile_rstn,
    input  wire logic [`HPM_PIPE_EVENTS-1:0]                   pipe_events_i,   // events 1..8
    input  wire logic [`HPM_MEM_EVENTS-1:0]                    mem_events_i,    // events 9..14
    input  wire logic [`HPM_EXT_EVENTS-1:0]                    ext_events_i,    // events 15..16
    input  wire hpm_types_pkg::cnt_mask_t                      sel_we_i,        // one hot
    input  wire hpm_types_pkg::event_sel_t                     sel_wdata_i,
    input  wire hpm_types_pkg::cnt_mask_t                      inhibit_i,       // mcountinhibit
    output hpm_types_pkg::event_sel_t [`HPM_NUM_COUNTERS-1:0]  sel_o,
    output hpm_types_pkg::cnt_mask_t                           cnt_inc_o
);

    import hpm_types_pkg::*;

    event_vec_t                             events_d;   // packed flag groups
    event_vec_t                             events_q;   // sample register
    logic [(1 << `HPM_SEL_WIDTH)-1:0]       ev_by_num;  // indexed by event number
    event_sel_t [`HPM_NUM_COUNTERS-1:0]     sel_q;      // mhpmevent3..6
    cnt_mask_t                              hit;        // selected event seen

    // ----------------------------------------
    // event sampling
    // ----------------------------------------

    assign events_d = {ext_events_i, mem_events_i, pipe_events_i};     // bit k = event k+1

    always_ff @(posedge clk_i, negedge tile_rstn) begin
        if (!tile_rstn) begin
            events_q <= '0;
        end else begin
            events_q <= events_d;   // one edge from pins to counters' view
        end
    end

    // spread out so that the selector value indexes directly
    // bit 0 and everything past the last event stay low
    always_comb begin
        ev_by_num                       = '0;
        ev_by_num[`HPM_NUM_EVENTS:1]    = events_q;
    end

    // ----------------------------------------
    // selector registers
    // ----------------------------------------

    always_ff @(posedge clk_i, negedge tile_rstn) begin
        if (!tile_rstn) begin
            sel_q <= '0;
        end else begin
            for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
                if (sel_we_i[i]) begin
                    sel_q[i] <= sel_wdata_i;    // csr write, low bits only
                end
            end
        end
    end

    assign sel_o = sel_q;

    // ----------------------------------------
    // increment request per counter
    // ----------------------------------------

    always_comb begin
        for (int i = 0; i < `HPM_NUM_COUNTERS; i++) begin
            hit[i] = ev_by_num[sel_q[i]];   // 0 and >16 read a low bit
        end
    end

    assign cnt_inc_o = hit & ~inhibit_i;    // inhibited counters never see an increment

    // decoder in the csr port must never hit two selectors at once
    a_sel_we_onehot : assert property (
        @(posedge clk_i) disable iff (!tile_rstn) $onehot0(sel_we_i)
    ) else $error("hpm_event_select: more than one selector write strobe");

endmodule

`default_nettype wire

//--- source/hpm_types_pkg.sv
`default_nettype none

`include "hpm_consts.svh"

package hpm_types_pkg;

    // ----------------------------------------
    // event side
    // ----------------------------------------

    // sampled event lines, bit k carries event number k+1
    typedef logic [`HPM_NUM_EVENTS-1:0] event_vec_t;

    // per counter event number
    // zero selects nothing, anything past the last event counts nothing
    typedef logic [`HPM_SEL_WIDTH-1:0] event_sel_t;

    // ----------------------------------------
    // counter side
    // ----------------------------------------

    typedef logic [`HPM_CNT_WIDTH-1:0] counter_t;     // one counter value

    // one bit per counter, index 0 is mhpmcounter3
    // shared by inhibit, increment, write strobes and overflow
    typedef logic [`HPM_NUM_COUNTERS-1:0] cnt_mask_t;

endpackage

`default_nettype wire

//--- source/pmu_tile_top.sv
`default_nettype none

`include "hpm_consts.svh"

module pmu_tile_top (
    input  wire logic                          clk_i,
    input  wire logic                          rstn_i,         // hard reset
    input  wire logic                          soft_rstn_i,    // software reset
    input  wire logic [`HPM_PIPE_EVENTS-1:0]   pipe_events_i,
    input  wire logic [`HPM_MEM_EVENTS-1:0]    mem_events_i,
    input  wire logic [`HPM_EXT_EVENTS-1:0]    ext_events_i,   // external cache events
    input  wire logic                          csr_re_i,
    input  wire logic                          csr_we_i,
    input  wire csr_access_pkg::csr_addr_t     csr_addr_i,
    input  wire csr_access_pkg::csr_data_t     csr_wdata_i,
    output csr_access_pkg::csr_data_t          csr_rdata_o,
    output logic                               csr_rvalid_o,
    output logic                               ovf_irq_o
);

    import hpm_types_pkg::*;

    logic                               tile_rstn;
    event_sel_t                         sel_wdata;      // write data cut to a selector
    cnt_mask_t                          mask_wdata;     // write data cut to a counter mask
    cnt_mask_t                          sel_we;
    cnt_mask_t                          cnt_we;
    cnt_mask_t                          cnt_inc;
    cnt_mask_t                          inhibit;
    cnt_mask_t                          ovf_bits;
    logic                               inhibit_we;
    logic                               ovf_clr_we;
    event_sel_t [`HPM_NUM_COUNTERS-1:0] sel;
    counter_t [`HPM_NUM_COUNTERS-1:0]   counters;

    // either reset source clears the whole tile
    assign tile_rstn  = rstn_i & soft_rstn_i;

    assign sel_wdata  = csr_wdata_i[`HPM_SEL_WIDTH-1:0];
    assign mask_wdata = csr_wdata_i[`HPM_NUM_COUNTERS-1:0];

    // ----------------------------------------
    // event side
    // ----------------------------------------

    hpm_event_select u_event_select (
        .clk_i         (clk_i),
        .tile_rstn     (tile_rstn),
        .pipe_events_i (pipe_events_i),
        .mem_events_i  (mem_events_i),
        .ext_events_i  (ext_events_i),
        .sel_we_i      (sel_we),
        .sel_wdata_i   (sel_wdata),
        .inhibit_i     (inhibit),
        .sel_o         (sel),
        .cnt_inc_o     (cnt_inc)
    );

    // ----------------------------------------
    // counters
    // ----------------------------------------

    hpm_counter_bank u_counter_bank (
        .clk_i        (clk_i),
        .tile_rstn    (tile_rstn),
        .cnt_inc_i    (cnt_inc),
        .cnt_we_i     (cnt_we),
        .cnt_wdata_i  (csr_wdata_i),     // full width counter write
        .inhibit_we_i (inhibit_we),
        .ovf_clr_we_i (ovf_clr_we),
        .mask_wdata_i (mask_wdata),
        .counters_o   (counters),
        .inhibit_o    (inhibit),
        .ovf_bits_o   (ovf_bits)
    );

    // ----------------------------------------
    // csr access and interrupt
    // ----------------------------------------

    hpm_csr_port u_csr_port (
        .clk_i        (clk_i),
        .tile_rstn    (tile_rstn),
        .csr_re_i     (csr_re_i),
        .csr_we_i     (csr_we_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .sel_i        (sel),
        .counters_i   (counters),
        .inhibit_i    (inhibit),
        .ovf_bits_i   (ovf_bits),
        .sel_we_o     (sel_we),
        .cnt_we_o     (cnt_we),
        .inhibit_we_o (inhibit_we),
        .ovf_clr_we_o (ovf_clr_we),
        .csr_rdata_o  (csr_rdata_o),
        .csr_rvalid_o (csr_rvalid_o),
        .ovf_irq_o    (ovf_irq_o)
    );

endmodule

`default_nettype wire
